// File: logic/opq_cfg_pkg.sv
////////////////////////////////////////
// Operand queue configuration
// Word and count sizes, buffer depths
// and the basic data types of one lane
////////////////////////////////////////

package opq_cfg_pkg;

  // One operand word as read from the register file
  localparam int unsigned ElenWidth = 64;
  // Element count of one command
  localparam int unsigned VlWidth = 16;

  // Buffer depths
  localparam int unsigned CmdBufDepth = 2;
  localparam int unsigned DataBufDepth = 2;

  // Credit count must be able to hold DataBufDepth itself
  localparam int unsigned DataCntWidth = $clog2(DataBufDepth + 1);

  // Up to 8 parts per word, for widening by 8
  localparam int unsigned PartIdxWidth = 3;

  typedef logic [ElenWidth-1:0] elen_t;
  typedef logic [VlWidth-1:0] vlen_t;
  typedef logic [PartIdxWidth-1:0] part_idx_t;

endpackage : opq_cfg_pkg

// File: logic/opq_cmd_pkg.sv
////////////////////////////////////////
// Operand queue command format
// Element width, conversion and target
// encodings, plus the conversion decode
////////////////////////////////////////

package opq_cmd_pkg;

  // Source element width
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } eew_e;

  // Integer widening kinds
  typedef enum logic [2:0] {
    ConvNone  = 3'd0,
    ConvSext2 = 3'd1,
    ConvSext4 = 3'd2,
    ConvSext8 = 3'd3,
    ConvZext2 = 3'd4,
    ConvZext4 = 3'd5,
    ConvZext8 = 3'd6
  } conv_e;

  // Default encoding, slide/ALU is zero
  typedef enum logic {
    FuAluSldu     = 1'b0,
    FuMfpuAddrgen = 1'b1
  } target_fu_e;

  typedef struct packed {
    opq_cfg_pkg::vlen_t vl;
    eew_e               eew;
    conv_e              conv;
    target_fu_e         target_fu;
  } opq_cmd_t;

  // Log2 of the widening factor, zero for pass-through
  function automatic logic [1:0] conv_log2_factor(conv_e conv, eew_e eew);
    logic [1:0] log2f;
    logic [2:0] dst_log2;
    case (conv)
      ConvSext2, ConvZext2: log2f = 2'd1;
      ConvSext4, ConvZext4: log2f = 2'd2;
      ConvSext8, ConvZext8: log2f = 2'd3;
      default:              log2f = 2'd0;
    endcase
    dst_log2 = {1'b0, eew} + {1'b0, log2f};
    // Destination wider than one word falls back to pass-through
    if (dst_log2 > 3'd3) begin
      log2f = 2'd0;
    end
    return log2f;
  endfunction

  function automatic logic conv_is_sext(conv_e conv);
    return conv inside {ConvSext2, ConvSext4, ConvSext8};
  endfunction

endpackage : opq_cmd_pkg

// File: logic/opq_head_if.sv
////////////////////////////////////////
// Buffer heads of the operand queue
// Command and data head with pop strobes
////////////////////////////////////////

`timescale 1ns/10ps

interface opq_head_if;
  import opq_cfg_pkg::*;
  import opq_cmd_pkg::*;

  // Command buffer head
  opq_cmd_t cmd;
  logic     cmd_empty;
  logic     cmd_pop;

  // Data buffer head
  elen_t data;
  logic  data_empty;
  logic  data_pop;

  // Buffer side drives the heads and takes the pops
  modport buf_mp (output cmd, cmd_empty, data, data_empty, input cmd_pop, data_pop);

  // Issue control only needs the command and the fill state
  modport ctrl_mp (input cmd, cmd_empty, data_empty, output cmd_pop, data_pop);

endinterface : opq_head_if

// File: logic/opq_fifo.sv
////////////////////////////////////////
// Operand queue FIFO
// Circular buffer for any payload type
// with the head valid one cycle after a push
////////////////////////////////////////

`timescale 1ns/10ps

module opq_fifo #(
  parameter type         payload_t = opq_cfg_pkg::elen_t,
  parameter int unsigned Depth     = opq_cfg_pkg::DataBufDepth
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     push_i,
  input  payload_t data_i,
  input  logic     pop_i,
  output payload_t data_o,
  output logic     empty_o,
  output logic     full_o
);

  // Payload storage
  payload_t mem_q [Depth];

  logic [$clog2(Depth)-1:0]   wr_ptr_q, rd_ptr_q;
  logic [$clog2(Depth+1)-1:0] cnt_q;

  // Pointer step that wraps at any Depth
  function automatic logic [$clog2(Depth)-1:0] next_ptr(logic [$clog2(Depth)-1:0] ptr);
    return (ptr == ($clog2(Depth))'(Depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop_i) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      // Count stays put on a simultaneous push and pop
      if (push_i && !pop_i) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (pop_i && !push_i) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  assign data_o  = mem_q[rd_ptr_q];
  assign empty_o = (cnt_q == '0);
  assign full_o  = (cnt_q == ($clog2(Depth+1))'(Depth));

  // Never pushed when full and never popped when empty
  assert property (@(posedge clk_i) disable iff (!rst_ni) push_i |-> !full_o);
  assert property (@(posedge clk_i) disable iff (!rst_ni) pop_i |-> !empty_o);

endmodule : opq_fifo

// File: logic/opq_credit_counter.sv
////////////////////////////////////////
// Data buffer credit counter
// Tracks requested plus buffered words
// so the data buffer never overflows
////////////////////////////////////////

`timescale 1ns/10ps

module opq_credit_counter (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic issued_i,
  input  logic consumed_i,
  output logic ready_o
);
  import opq_cfg_pkg::*;

  logic [DataCntWidth-1:0] usage_d, usage_q;

  always_comb begin
    usage_d = usage_q;
    // Issue and consume together leave the count alone
    case ({issued_i, consumed_i})
      2'b10:   usage_d = usage_q + 1'b1;
      2'b01:   usage_d = usage_q - 1'b1;
      default: usage_d = usage_q;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      usage_q <= '0;
    end else begin
      usage_q <= usage_d;
    end
  end

  // Registered usage only, so ready follows one cycle late
  assign ready_o = (usage_q < DataCntWidth'(DataBufDepth));

  // Requester must stop issuing once credits are gone
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    usage_q <= DataCntWidth'(DataBufDepth));

endmodule : opq_credit_counter

// File: logic/opq_widen_unit.sv
////////////////////////////////////////
// Integer widening of one word part
// Sign or zero extension by 2, 4 or 8,
// pass-through for none or illegal
////////////////////////////////////////

`timescale 1ns/10ps

module opq_widen_unit (
  input  opq_cfg_pkg::elen_t     word_i,
  input  opq_cmd_pkg::eew_e      eew_i,
  input  opq_cmd_pkg::conv_e     conv_i,
  input  opq_cfg_pkg::part_idx_t part_i,
  output opq_cfg_pkg::elen_t     operand_o
);
  import opq_cfg_pkg::*;
  import opq_cmd_pkg::*;

  logic [1:0] log2f;
  logic       sext;
  // First source bit of the selected part
  logic [$clog2(ElenWidth)-1:0] base;

  assign log2f = conv_log2_factor(conv_i, eew_i);
  assign sext  = conv_is_sext(conv_i);

  // Part p covers 64/F source bits starting at p*64/F
  always_comb begin
    case (log2f)
      2'd1:    base = {part_i[0], 5'b0};
      2'd2:    base = {part_i[1:0], 4'b0};
      2'd3:    base = {part_i, 3'b0};
      default: base = '0;
    endcase
  end

  always_comb begin
    // Default is the word unchanged
    operand_o = word_i;
    case (log2f)
      // Widen by 2
      2'd1: begin
        case (eew_i)
          EW8: for (int e = 0; e < 4; e++) begin
            operand_o[16*e +: 16] = {{8{sext && word_i[base + 8*e + 7]}},
                                     word_i[base + 8*e +: 8]};
          end
          EW16: for (int e = 0; e < 2; e++) begin
            operand_o[32*e +: 32] = {{16{sext && word_i[base + 16*e + 15]}},
                                     word_i[base + 16*e +: 16]};
          end
          EW32: operand_o = {{32{sext && word_i[base + 31]}}, word_i[base +: 32]};
          default: operand_o = word_i;
        endcase
      end
      // Widen by 4
      2'd2: begin
        case (eew_i)
          EW8: for (int e = 0; e < 2; e++) begin
            operand_o[32*e +: 32] = {{24{sext && word_i[base + 8*e + 7]}},
                                     word_i[base + 8*e +: 8]};
          end
          EW16: operand_o = {{48{sext && word_i[base + 15]}}, word_i[base +: 16]};
          default: operand_o = word_i;
        endcase
      end
      // Widen by 8, byte to double word
      2'd3: operand_o = {{56{sext && word_i[base + 7]}}, word_i[base +: 8]};
      default: operand_o = word_i;
    endcase
  end

endmodule : opq_widen_unit

// File: logic/opq_issue_ctrl.sv
////////////////////////////////////////
// Operand issue control
// Part and element counters, output
// valid and the pops of both buffers
////////////////////////////////////////

`timescale 1ns/10ps

module opq_issue_ctrl (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  opq_head_if.ctrl_mp            head,
  input  logic                   operand_ready_i,
  output logic                   operand_valid_o,
  output opq_cfg_pkg::part_idx_t part_o
);
  import opq_cfg_pkg::*;
  import opq_cmd_pkg::*;

  part_idx_t        part_d, part_q;
  part_idx_t        part_next;
  part_idx_t        part_mask;
  vlen_t            vl_d, vl_q;
  vlen_t            elems;
  logic [VlWidth:0] vl_next;
  logic [1:0]       log2f;
  logic [2:0]       dst_log2;
  logic             transfer;
  logic             cmd_done;

  ////////////////////////////////////////
  // Output handshake
  ////////////////////////////////////////

  // Valid needs both a command and a word at the heads
  assign operand_valid_o = !head.cmd_empty && !head.data_empty;
  assign transfer        = operand_valid_o && operand_ready_i;
  assign part_o          = part_q;

  ////////////////////////////////////////
  // Counters
  ////////////////////////////////////////

  assign log2f    = conv_log2_factor(head.cmd.conv, head.cmd.eew);
  assign dst_log2 = {1'b0, head.cmd.eew} + {1'b0, log2f};
  // Elements per output word, 64 over destination width
  assign elems    = vlen_t'(4'd8 >> dst_log2);

  // Part index wraps after F parts, at once for F of 1
  assign part_mask = part_idx_t'((4'd1 << log2f) - 4'd1);
  assign part_next = (part_q + 3'd1) & part_mask;

  // One extra bit so the compare cannot wrap
  assign vl_next  = {1'b0, vl_q} + {1'b0, elems};
  assign cmd_done = (vl_next >= {1'b0, head.cmd.vl});

  always_comb begin
    part_d        = part_q;
    vl_d          = vl_q;
    head.data_pop = 1'b0;
    head.cmd_pop  = 1'b0;
    if (transfer) begin
      part_d = part_next;
      vl_d   = vl_next[VlWidth-1:0];
      // Word used up
      if (part_next == '0) begin
        head.data_pop = 1'b1;
      end
      // Command finished, drop the word too and start over
      if (cmd_done) begin
        head.data_pop = 1'b1;
        head.cmd_pop  = 1'b1;
        part_d        = '0;
        vl_d          = '0;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      part_q <= '0;
      vl_q   <= '0;
    end else begin
      part_q <= part_d;
      vl_q   <= vl_d;
    end
  end

  // Pops only ever come with an accepted transfer
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (head.data_pop || head.cmd_pop) |-> transfer);

  // An offered operand stays offered until it is taken
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (operand_valid_o && !operand_ready_i) |=> operand_valid_o);

endmodule : opq_issue_ctrl

// File: logic/operand_queue.sv
////////////////////////////////////////
// Operand queue, one vector lane
// Buffers commands and register file
// words and issues them, optionally
// widened, to the functional units
////////////////////////////////////////

`timescale 1ns/10ps

module operand_queue (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // Operand requester
  input  opq_cmd_pkg::opq_cmd_t   cmd_i,
  input  logic                    cmd_valid_i,
  // Register file
  input  opq_cfg_pkg::elen_t      operand_i,
  input  logic                    operand_valid_i,
  input  logic                    operand_issued_i,
  output logic                    operand_queue_ready_o,
  // Functional units
  output opq_cfg_pkg::elen_t      operand_o,
  output opq_cmd_pkg::target_fu_e operand_target_fu_o,
  output logic                    operand_valid_o,
  input  logic                    operand_ready_i
);
  import opq_cfg_pkg::*;
  import opq_cmd_pkg::*;

  opq_head_if head_if ();
  part_idx_t  part;

  ////////////////////////////////////////
  // Buffers
  ////////////////////////////////////////

  opq_fifo #(
    .payload_t(opq_cmd_t),
    .Depth    (CmdBufDepth)
  ) i_cmd_buffer (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .push_i (cmd_valid_i),
    .data_i (cmd_i),
    .pop_i  (head_if.cmd_pop),
    .data_o (head_if.cmd),
    .empty_o(head_if.cmd_empty),
    .full_o ()
  );

  // Credits keep this one from ever filling past its depth
  opq_fifo #(
    .payload_t(elen_t),
    .Depth    (DataBufDepth)
  ) i_data_buffer (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .push_i (operand_valid_i),
    .data_i (operand_i),
    .pop_i  (head_if.data_pop),
    .data_o (head_if.data),
    .empty_o(head_if.data_empty),
    .full_o ()
  );

  opq_credit_counter i_credit_counter (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .issued_i  (operand_issued_i),
    .consumed_i(head_if.data_pop),
    .ready_o   (operand_queue_ready_o)
  );

  ////////////////////////////////////////
  // Conversion and issue
  ////////////////////////////////////////

  opq_widen_unit i_widen_unit (
    .word_i   (head_if.data),
    .eew_i    (head_if.cmd.eew),
    .conv_i   (head_if.cmd.conv),
    .part_i   (part),
    .operand_o(operand_o)
  );

  opq_issue_ctrl i_issue_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .head           (head_if.ctrl_mp),
    .operand_ready_i(operand_ready_i),
    .operand_valid_o(operand_valid_o),
    .part_o         (part)
  );

  // Target unit comes straight from the head command
  assign operand_target_fu_o = head_if.cmd.target_fu;

endmodule : operand_queue

// File: tb/tb_operand_queue.sv
////////////////////////////////////////
// Operand queue testbench
// Directed tests for credits, widening,
// back-pressure and partial commands
////////////////////////////////////////

`timescale 1ns/10ps

module tb_operand_queue;
  import opq_cfg_pkg::*;
  import opq_cmd_pkg::*;

  logic       clk;
  logic       rst_n;
  opq_cmd_t   cmd;
  logic       cmd_valid;
  elen_t      operand_in;
  logic       operand_valid_in;
  logic       operand_issued;
  logic       queue_ready;
  elen_t      operand_out;
  target_fu_e target_fu;
  logic       operand_valid_out;
  logic       operand_ready;

  int unsigned errors;
  int unsigned timeouts;

  // Words to send, expected outputs and their target units
  elen_t      word_q[$];
  elen_t      exp_q[$];
  target_fu_e fu_q[$];

  operand_queue operand_queue_inst (
    .clk_i                (clk),
    .rst_ni               (rst_n),
    .cmd_i                (cmd),
    .cmd_valid_i          (cmd_valid),
    .operand_i            (operand_in),
    .operand_valid_i      (operand_valid_in),
    .operand_issued_i     (operand_issued),
    .operand_queue_ready_o(queue_ready),
    .operand_o            (operand_out),
    .operand_target_fu_o  (target_fu),
    .operand_valid_o      (operand_valid_out),
    .operand_ready_i      (operand_ready)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  // Widening factor that falls back to 1 when the destination exceeds one word
  function automatic int effective_factor(conv_e conv, eew_e eew);
    int f;
    case (conv)
      ConvSext2, ConvZext2: f = 2;
      ConvSext4, ConvZext4: f = 4;
      ConvSext8, ConvZext8: f = 8;
      default:              f = 1;
    endcase
    if ((8 << eew) * f > 64) f = 1;
    return f;
  endfunction

  function automatic elen_t widen_ref(elen_t word, eew_e eew, conv_e conv, int part);
    int    f;
    int    sw;
    int    dw;
    logic  sext;
    elen_t chunk;
    elen_t elem;
    elen_t smask;
    elen_t dmask;
    elen_t res;
    f     = effective_factor(conv, eew);
    sw    = 8 << eew;
    dw    = sw * f;
    sext  = (conv == ConvSext2) || (conv == ConvSext4) || (conv == ConvSext8);
    if (f == 1) return word;
    // Source part p starts at bit p*64/F
    chunk = word >> (part * (64 / f));
    smask = (64'd1 << sw) - 64'd1;
    dmask = (dw == 64) ? '1 : ((64'd1 << dw) - 64'd1);
    res   = '0;
    for (int e = 0; e < 64 / dw; e++) begin
      elem = (chunk >> (e * sw)) & smask;
      if (sext && elem[sw-1]) elem = elem | ~smask;
      res = res | ((elem & dmask) << (e * dw));
    end
    return res;
  endfunction

  // Queues the expected outputs of one command and returns the first word of the next
  function automatic int model_cmd(opq_cmd_t c, int wi);
    int f;
    int dw;
    int cnt;
    int part;
    f    = effective_factor(c.conv, c.eew);
    dw   = (8 << c.eew) * f;
    cnt  = 0;
    part = 0;
    while (cnt < c.vl) begin
      exp_q.push_back(widen_ref(word_q[wi], c.eew, c.conv, part));
      fu_q.push_back(c.target_fu);
      cnt  = cnt + 64 / dw;
      part = part + 1;
      if (part == f) begin
        part = 0;
        wi   = wi + 1;
      end
    end
    // A finished command drops the rest of its word
    if (part != 0) wi = wi + 1;
    return wi;
  endfunction

  function automatic opq_cmd_t make_cmd(int vl, eew_e eew, conv_e conv, target_fu_e fu);
    opq_cmd_t c;
    c.vl        = vlen_t'(vl);
    c.eew       = eew;
    c.conv      = conv;
    c.target_fu = fu;
    return c;
  endfunction

  ////////////////////////////////////////
  // Bus tasks
  ////////////////////////////////////////

  task automatic send_cmd(input opq_cmd_t c);
    @(posedge clk);
    cmd       <= c;
    cmd_valid <= 1'b1;
    @(posedge clk);
    cmd_valid <= 1'b0;
  endtask

  task automatic wait_ready(input logic level, input string what);
    int n;
    n = 0;
    @(negedge clk);
    while (queue_ready !== level) begin
      n++;
      if (n > 100) begin
        $display("Timeout: queue ready never reached %0b during %s", level, what);
        timeouts++;
        return;
      end
      @(negedge clk);
    end
  endtask

  // Push one word with or without a matching issue pulse
  task automatic push_word(input elen_t w, input logic issue);
    @(posedge clk);
    operand_in       <= w;
    operand_valid_in <= 1'b1;
    operand_issued   <= issue;
    @(posedge clk);
    operand_valid_in <= 1'b0;
    operand_issued   <= 1'b0;
  endtask

  // Requester issues only while credits remain
  task automatic send_word(input elen_t w);
    wait_ready(1'b1, "send_word");
    push_word(w, 1'b1);
  endtask

  task automatic wait_valid(input string what, output logic ok);
    int n;
    n  = 0;
    ok = 1'b1;
    @(negedge clk);
    while (operand_valid_out !== 1'b1) begin
      n++;
      if (n > 100) begin
        $display("Timeout: no operand offered during %s", what);
        timeouts++;
        ok = 1'b0;
        return;
      end
      @(negedge clk);
    end
  endtask

  // Check the offered operand and accept it for exactly one cycle
  task automatic consume_one(input string name, input elen_t exp, input target_fu_e fu);
    logic ok;
    wait_valid(name, ok);
    if (!ok) return;
    if (operand_out !== exp) begin
      $display("Fail %s: expected %h, actual %h", name, exp, operand_out);
      errors++;
    end
    if (target_fu !== fu) begin
      $display("Fail %s target: expected %0d, actual %0d", name, fu, target_fu);
      errors++;
    end
    @(posedge clk);
    operand_ready <= 1'b1;
    @(posedge clk);
    operand_ready <= 1'b0;
  endtask

  // Feed all queued words while draining all expected outputs
  task automatic run_stream(input string name);
    fork
      begin
        for (int i = 0; i < word_q.size(); i++) send_word(word_q[i]);
      end
      begin
        for (int i = 0; i < exp_q.size(); i++) begin
          consume_one($sformatf("%s[%0d]", name, i), exp_q[i], fu_q[i]);
        end
      end
    join
    word_q.delete();
    exp_q.delete();
    fu_q.delete();
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////

  task automatic test_credits();
    opq_cmd_t c;
    elen_t    w0;
    elen_t    w1;
    c  = make_cmd(2, EW64, ConvNone, FuMfpuAddrgen);
    w0 = {$urandom, $urandom};
    w1 = {$urandom, $urandom};
    @(negedge clk);
    if (operand_valid_out !== 1'b0) begin
      $display("Fail credits_reset_valid: expected 0, actual %b", operand_valid_out);
      errors++;
    end
    if (queue_ready !== 1'b1) begin
      $display("Fail credits_reset_ready: expected 1, actual %b", queue_ready);
      errors++;
    end
    // Use up every credit without delivering data
    for (int i = 0; i < DataBufDepth; i++) begin
      @(posedge clk);
      operand_issued <= 1'b1;
    end
    @(posedge clk);
    operand_issued <= 1'b0;
    wait_ready(1'b0, "credits exhausted");
    // Requested words arrive without a new issue
    send_cmd(c);
    push_word(w0, 1'b0);
    push_word(w1, 1'b0);
    consume_one("credits_first", w0, FuMfpuAddrgen);
    wait_ready(1'b1, "credit return");
    consume_one("credits_second", w1, FuMfpuAddrgen);
  endtask

  task automatic test_pass_through();
    opq_cmd_t c;
    c = make_cmd(6, EW32, ConvNone, FuMfpuAddrgen);
    for (int i = 0; i < 3; i++) word_q.push_back({$urandom, $urandom});
    void'(model_cmd(c, 0));
    send_cmd(c);
    run_stream("pass_through");
  endtask

  task automatic test_widen2(input conv_e conv, input string name);
    opq_cmd_t c;
    elen_t    w;
    c = make_cmd(16, EW8, conv, FuAluSldu);
    // Force one negative and one positive byte at the start
    w = {$urandom, $urandom};
    w[15:0] = 16'h3c85;
    word_q.push_back(w);
    word_q.push_back({$urandom, $urandom});
    void'(model_cmd(c, 0));
    send_cmd(c);
    run_stream(name);
  endtask

  task automatic test_widen4_8();
    opq_cmd_t c4;
    opq_cmd_t c8;
    int       wi;
    c4 = make_cmd(8, EW8, ConvSext4, FuAluSldu);
    c8 = make_cmd(8, EW8, ConvZext8, FuMfpuAddrgen);
    word_q.push_back({$urandom, $urandom});
    word_q.push_back({$urandom, $urandom});
    wi = model_cmd(c4, 0);
    void'(model_cmd(c8, wi));
    send_cmd(c4);
    send_cmd(c8);
    run_stream("widen4_8");
  endtask

  task automatic test_back_pressure();
    opq_cmd_t c;
    logic     ok;
    elen_t    held;
    c = make_cmd(4, EW16, ConvSext2, FuAluSldu);
    word_q.push_back({$urandom, $urandom});
    void'(model_cmd(c, 0));
    send_cmd(c);
    send_word(word_q[0]);
    wait_valid("back_pressure", ok);
    if (ok) begin
      held = operand_out;
      // Offer must not move while ready stays low
      repeat (6) begin
        @(negedge clk);
        if (operand_valid_out !== 1'b1) begin
          $display("Fail back_pressure_valid: expected 1, actual %b", operand_valid_out);
          errors++;
        end
        if (operand_out !== held) begin
          $display("Fail back_pressure_hold: expected %h, actual %h", held, operand_out);
          errors++;
        end
      end
    end
    consume_one("back_pressure[0]", exp_q[0], fu_q[0]);
    consume_one("back_pressure[1]", exp_q[1], fu_q[1]);
    word_q.delete();
    exp_q.delete();
    fu_q.delete();
  endtask

  task automatic test_partial_vl();
    opq_cmd_t c0;
    opq_cmd_t c1;
    int       wi;
    c0 = make_cmd(5, EW16, ConvNone, FuAluSldu);
    c1 = make_cmd(1, EW64, ConvNone, FuMfpuAddrgen);
    for (int i = 0; i < 3; i++) word_q.push_back({$urandom, $urandom});
    wi = model_cmd(c0, 0);
    void'(model_cmd(c1, wi));
    send_cmd(c0);
    send_cmd(c1);
    run_stream("partial_vl");
    @(negedge clk);
    if (operand_valid_out !== 1'b0) begin
      $display("Fail partial_vl_drain: expected 0, actual %b", operand_valid_out);
      errors++;
    end
  endtask

  initial begin
    errors           = 0;
    timeouts         = 0;
    rst_n            = 1'b0;
    cmd              = '0;
    cmd_valid        = 1'b0;
    operand_in       = '0;
    operand_valid_in = 1'b0;
    operand_issued   = 1'b0;
    operand_ready    = 1'b0;
    void'($urandom(32'h2e40_e7a0));
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;

    test_credits();
    test_pass_through();
    test_widen2(ConvSext2, "sext2");
    test_widen2(ConvZext2, "zext2");
    test_widen4_8();
    test_back_pressure();
    test_partial_vl();

    $display("Errors: %0d mismatches, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule : tb_operand_queue

// File: operand_queue.f
logic/opq_cfg_pkg.sv
logic/opq_cmd_pkg.sv
logic/opq_head_if.sv
logic/opq_fifo.sv
logic/opq_credit_counter.sv
logic/opq_widen_unit.sv
logic/opq_issue_ctrl.sv
logic/operand_queue.sv
tb/tb_operand_queue.sv
